// ==== src/dcache_pkg.sv ====
package dcache_pkg;

    localparam int LINE_WORDS = 4;
    localparam int NUM_WAYS   = 2;
    localparam int NUM_SETS   = 16;

    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  word_t;
    typedef logic [3:0]   strb_t;
    typedef logic [23:0]  tag_t;
    typedef logic [3:0]   index_t;
    typedef logic [1:0]   offset_t;
    typedef logic [1:0]   way_t;
    typedef logic [127:0] line_t;

    // op is 1 for a store
    typedef struct packed {
        logic  op;
        addr_t addr;
        word_t wdata;
        strb_t strb;
    } cpu_req_t;

    typedef struct packed {
        addr_t base;
        line_t data;
    } victim_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        evict,
        wb_wait,
        refill_req,
        refill,
        replay
    } cache_state_t;

endpackage

// ==== src/tagv_array.sv ====
`timescale 1ns/1ns

module tagv_array (
    input  logic                 clk,
    input  logic                 reset,
    input  dcache_pkg::cpu_req_t req,
    input  logic                 tag_we,
    input  dcache_pkg::way_t     way_sel,
    input  logic                 lru_update,
    input  logic                 set_dirty,
    output dcache_pkg::way_t     hit,
    output logic                 victim_dirty,
    output dcache_pkg::tag_t     victim_tag,
    output dcache_pkg::way_t     lru_way
);
    import dcache_pkg::*;

    tag_t                                tags [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0][NUM_WAYS-1:0]   valid;
    logic [NUM_SETS-1:0][NUM_WAYS-1:0]   dirty;
    // set means way 1 is the next victim
    logic [NUM_SETS-1:0]                 lru;
    tag_t                                req_tag;
    index_t                              idx;

    assign req_tag = req.addr[31:8];
    assign idx     = req.addr[7:4];

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit[w] = valid[idx][w] && (tags[w][idx] == req_tag);
        end
    end

    assign lru_way      = lru[idx] ? 2'b10 : 2'b01;
    assign victim_tag   = lru[idx] ? tags[1][idx] : tags[0][idx];
    assign victim_dirty = |(lru_way & valid[idx] & dirty[idx]);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else begin
            if (tag_we) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    if (way_sel[w]) begin
                        valid[idx][w] <= 1'b1;
                        dirty[idx][w] <= set_dirty;
                    end
                end
            end
            // point away from the way just used
            if (lru_update) begin
                lru[idx] <= way_sel[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (tag_we && way_sel[w]) begin
                tags[w][idx] <= req_tag;
            end
        end
    end

endmodule

// ==== src/data_store.sv ====
`timescale 1ns/1ns

module data_store (
    input  logic                clk,
    input  dcache_pkg::index_t  index,
    input  dcache_pkg::offset_t offset,
    input  dcache_pkg::way_t    way_sel,
    input  logic                word_we,
    input  dcache_pkg::strb_t   strb,
    input  dcache_pkg::word_t   wdata,
    input  logic                fill_en,
    input  dcache_pkg::line_t   fill_line,
    output dcache_pkg::word_t   rdata,
    output dcache_pkg::line_t   line_out
);
    import dcache_pkg::*;

    line_t mem [NUM_WAYS][NUM_SETS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_sel[w]) begin
                if (fill_en) begin
                    mem[w][index] <= fill_line;
                end else if (word_we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (strb[b]) begin
                            mem[w][index][32*offset + 8*b +: 8] <= wdata[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    // way_sel is one-hot
    assign line_out = way_sel[1] ? mem[1][index] : mem[0][index];
    assign rdata    = line_out[32*offset +: 32];

endmodule

// ==== src/refill_buffer.sv ====
`timescale 1ns/1ns

module refill_buffer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  dcache_pkg::cpu_req_t req,
    input  logic                 ret_valid,
    input  logic                 ret_last,
    input  dcache_pkg::word_t    r_data,
    output dcache_pkg::line_t    line,
    output logic                 fill_done
);
    import dcache_pkg::*;

    offset_t cnt;
    offset_t st_off;
    line_t   line_next;

    assign st_off = req.addr[3:2];

    always_comb begin
        line_next = line;
        line_next[32*cnt +: 32] = r_data;
        // pending store lands on top of the fetched line
        if (ret_last && req.op) begin
            for (int b = 0; b < 4; b++) begin
                if (req.strb[b]) begin
                    line_next[32*st_off + 8*b +: 8] = req.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt       <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= ret_valid && ret_last;
            if (start) begin
                cnt <= '0;
            end else if (ret_valid) begin
                cnt <= cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ret_valid) begin
            line <= line_next;
        end
    end

endmodule

// ==== src/writeback_buffer.sv ====
`timescale 1ns/1ns

module writeback_buffer (
    input  logic                clk,
    input  logic                reset,
    input  logic                load,
    input  dcache_pkg::victim_t victim,
    input  logic                w_rdy,
    input  logic                w_data_ready,
    input  logic                b_valid,
    output dcache_pkg::addr_t   w_addr,
    output logic                w_data_req,
    output dcache_pkg::word_t   w_data,
    output logic                w_last,
    output logic                b_ready,
    output logic                wb_done
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        wb_idle,
        wb_addr,
        wb_data,
        wb_resp
    } wb_state_t;

    wb_state_t state;
    offset_t   beat;
    victim_t   held;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= wb_idle;
            beat  <= '0;
        end else begin
            case (state)
                wb_idle: begin
                    beat <= '0;
                    if (load) begin
                        state <= wb_addr;
                    end
                end
                // address phase runs alongside the controller's w_req
                wb_addr: begin
                    if (w_rdy) begin
                        state <= wb_data;
                    end
                end
                wb_data: begin
                    if (w_data_ready) begin
                        beat <= beat + 2'd1;
                        if (w_last) begin
                            state <= wb_resp;
                        end
                    end
                end
                wb_resp: begin
                    if (b_valid) begin
                        state <= wb_idle;
                    end
                end
                default: state <= wb_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            held <= victim;
        end
    end

    assign w_addr     = held.base;
    assign w_data     = held.data[32*beat +: 32];
    assign w_data_req = (state == wb_data);
    assign w_last     = w_data_req && (beat == offset_t'(LINE_WORDS - 1));
    assign b_ready    = (state == wb_resp);
    assign wb_done    = b_ready && b_valid;

endmodule

// ==== src/cache_fsm.sv ====
`timescale 1ns/1ns

module cache_fsm (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  dcache_pkg::cpu_req_t req,
    input  dcache_pkg::way_t     hit,
    input  logic                 victim_dirty,
    input  dcache_pkg::tag_t     victim_tag,
    input  dcache_pkg::way_t     lru_way,
    input  dcache_pkg::line_t    line_out,
    input  logic                 r_rdy,
    input  logic                 fill_done,
    input  logic                 wb_done,
    input  logic                 w_rdy,
    output logic                 accept,
    output logic                 tag_we,
    output logic                 data_we,
    output logic                 fill_en,
    output dcache_pkg::way_t     way_sel,
    output logic                 lru_update,
    output logic                 wb_load,
    output dcache_pkg::victim_t  victim,
    output logic                 refill_start,
    output logic                 r_req,
    output logic                 w_req,
    output logic                 done,
    output logic                 cache_ready
);
    import dcache_pkg::*;

    cache_state_t state;
    cache_state_t state_next;
    way_t         victim_way;
    logic         done_q;
    logic         hit_any;

    assign hit_any = |hit;

    // stays low through the data_valid cycle
    assign cache_ready = (state == idle) && !done_q;
    assign accept      = valid && cache_ready;

    // on a miss in lookup the LRU way is selected so line_out is the victim
    assign way_sel = (state == lookup) ? (hit_any ? hit : lru_way) : victim_way;

    assign victim.base = {victim_tag, req.addr[7:4], 4'b0000};
    assign victim.data = line_out;

    always_comb begin
        state_next   = state;
        tag_we       = 1'b0;
        data_we      = 1'b0;
        fill_en      = 1'b0;
        lru_update   = 1'b0;
        wb_load      = 1'b0;
        refill_start = 1'b0;
        r_req        = 1'b0;
        w_req        = 1'b0;
        done         = 1'b0;
        case (state)
            idle: begin
                if (accept) begin
                    state_next = lookup;
                end
            end
            lookup: begin
                if (hit_any) begin
                    // store hit rewrites the tag entry with dirty set
                    tag_we     = req.op;
                    data_we    = req.op;
                    lru_update = 1'b1;
                    done       = 1'b1;
                    state_next = idle;
                end else if (victim_dirty) begin
                    wb_load    = 1'b1;
                    state_next = evict;
                end else begin
                    state_next = refill_req;
                end
            end
            evict: begin
                w_req = 1'b1;
                if (w_rdy) begin
                    state_next = wb_wait;
                end
            end
            wb_wait: begin
                if (wb_done) begin
                    state_next = refill_req;
                end
            end
            refill_req: begin
                r_req = 1'b1;
                if (r_rdy) begin
                    refill_start = 1'b1;
                    state_next   = refill;
                end
            end
            refill: begin
                // line already carries the store bytes
                if (fill_done) begin
                    fill_en    = 1'b1;
                    tag_we     = 1'b1;
                    lru_update = 1'b1;
                    state_next = replay;
                end
            end
            replay: begin
                done       = 1'b1;
                state_next = idle;
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= idle;
            done_q     <= 1'b0;
            victim_way <= 2'b01;
        end else begin
            state  <= state_next;
            done_q <= done;
            if (state == lookup && !hit_any) begin
                victim_way <= lru_way;
            end
        end
    end

endmodule

// ==== src/dcache.sv ====
`timescale 1ns/1ns

module dcache (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid,
    input  logic              op,
    input  dcache_pkg::addr_t addr,
    input  dcache_pkg::word_t wdata,
    input  dcache_pkg::strb_t strb,
    output dcache_pkg::word_t rdata,
    output logic              data_valid,
    output logic              cache_ready,
    output logic              r_req,
    output dcache_pkg::addr_t r_addr,
    output logic [7:0]        r_length,
    input  logic              r_rdy,
    input  logic              ret_valid,
    input  logic              ret_last,
    input  dcache_pkg::word_t r_data,
    output logic              w_req,
    output dcache_pkg::addr_t w_addr,
    output logic              w_data_req,
    output dcache_pkg::word_t w_data,
    output logic              w_last,
    output logic              b_ready,
    input  logic              w_rdy,
    input  logic              w_data_ready,
    input  logic              b_valid
);
    import dcache_pkg::*;

    cpu_req_t req_q;
    logic     accept;
    way_t     hit;
    way_t     lru_way;
    way_t     way_sel;
    tag_t     victim_tag;
    logic     victim_dirty;
    logic     tag_we;
    logic     data_we;
    logic     fill_en;
    logic     lru_update;
    logic     wb_load;
    logic     wb_done;
    logic     refill_start;
    logic     fill_done;
    logic     done;
    victim_t  victim;
    line_t    line_out;
    line_t    fill_line;
    word_t    store_rdata;

    assign r_addr   = {req_q.addr[31:4], 4'b0000};
    assign r_length = 8'(LINE_WORDS - 1);

    // request register
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= '{op: op, addr: addr, wdata: wdata, strb: strb};
        end
    end

    // output register
    always_ff @(posedge clk) begin
        if (reset) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= done;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            rdata <= store_rdata;
        end
    end

    cache_fsm u_fsm (
        .clk          (clk),
        .reset        (reset),
        .valid        (valid),
        .req          (req_q),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .lru_way      (lru_way),
        .line_out     (line_out),
        .r_rdy        (r_rdy),
        .fill_done    (fill_done),
        .wb_done      (wb_done),
        .w_rdy        (w_rdy),
        .accept       (accept),
        .tag_we       (tag_we),
        .data_we      (data_we),
        .fill_en      (fill_en),
        .way_sel      (way_sel),
        .lru_update   (lru_update),
        .wb_load      (wb_load),
        .victim       (victim),
        .refill_start (refill_start),
        .r_req        (r_req),
        .w_req        (w_req),
        .done         (done),
        .cache_ready  (cache_ready)
    );

    tagv_array u_tagv (
        .clk          (clk),
        .reset        (reset),
        .req          (req_q),
        .tag_we       (tag_we),
        .way_sel      (way_sel),
        .lru_update   (lru_update),
        .set_dirty    (req_q.op),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .lru_way      (lru_way)
    );

    data_store u_data (
        .clk       (clk),
        .index     (req_q.addr[7:4]),
        .offset    (req_q.addr[3:2]),
        .way_sel   (way_sel),
        .word_we   (data_we),
        .strb      (req_q.strb),
        .wdata     (req_q.wdata),
        .fill_en   (fill_en),
        .fill_line (fill_line),
        .rdata     (store_rdata),
        .line_out  (line_out)
    );

    refill_buffer u_refill (
        .clk       (clk),
        .reset     (reset),
        .start     (refill_start),
        .req       (req_q),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .r_data    (r_data),
        .line      (fill_line),
        .fill_done (fill_done)
    );

    writeback_buffer u_wb (
        .clk          (clk),
        .reset        (reset),
        .load         (wb_load),
        .victim       (victim),
        .w_rdy        (w_rdy),
        .w_data_ready (w_data_ready),
        .b_valid      (b_valid),
        .w_addr       (w_addr),
        .w_data_req   (w_data_req),
        .w_data       (w_data),
        .w_last       (w_last),
        .b_ready      (b_ready),
        .wb_done      (wb_done)
    );

endmodule

// ==== bench/dcache_properties.sv ====
`timescale 1ns/1ns

module dcache_properties (
    input logic clk,
    input logic reset,
    input logic r_req,
    input logic w_req,
    input logic data_valid,
    input logic cache_ready,
    input logic w_data_req,
    input logic w_last
);

    // read by the testbench each cycle
    int failures = 0;

    // one bus channel at a time
    no_dual_request: assert property (@(posedge clk) disable iff (reset) !(r_req && w_req))
        else begin
            $error("r_req and w_req high in the same cycle");
            failures++;
        end

    response_while_busy: assert property (
        @(posedge clk) disable iff (reset) data_valid |-> !cache_ready)
        else begin
            $error("data_valid while cache_ready is high");
            failures++;
        end

    last_inside_beat: assert property (@(posedge clk) disable iff (reset) w_last |-> w_data_req)
        else begin
            $error("w_last without w_data_req");
            failures++;
        end

endmodule

bind dcache dcache_properties i_props (
    .clk         (clk),
    .reset       (reset),
    .r_req       (r_req),
    .w_req       (w_req),
    .data_valid  (data_valid),
    .cache_ready (cache_ready),
    .w_data_req  (w_data_req),
    .w_last      (w_last)
);

// ==== bench/dcache_tb.sv ====
`timescale 1ns/1ns

module dcache_tb;
    import dcache_pkg::*;

    typedef struct packed {
        logic  st;
        addr_t addr;
        word_t data;
    } expect_t;

    localparam int num_directed   = 16;
    localparam int num_random     = 300;
    localparam int timeout_cycles = 400 * (num_directed + num_random);

    logic       clk;
    logic       reset;
    logic       valid;
    logic       op;
    addr_t      addr;
    word_t      wdata;
    strb_t      strb;
    word_t      rdata;
    logic       data_valid;
    logic       cache_ready;
    logic       r_req;
    addr_t      r_addr;
    logic [7:0] r_length;
    logic       r_rdy;
    logic       ret_valid;
    logic       ret_last;
    word_t      r_data;
    logic       w_req;
    addr_t      w_addr;
    logic       w_data_req;
    word_t      w_data;
    logic       w_last;
    logic       b_ready;
    logic       w_rdy;
    logic       w_data_ready;
    logic       b_valid;

    word_t   mem [256];
    word_t   shadow [256];
    expect_t exp_q [$];
    int      cycles = 0;
    int      issued = 0;
    int      resp_count = 0;
    int      accept_cycle = 0;
    int      last_latency = 0;
    int      fail_count = 0;
    int      wb_count = 0;
    int      wb_end_cycle = 0;
    int      rd_seen_cycle = 0;
    addr_t   last_wb_base;

    dcache i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_on_error(input string line);
        fail_count++;
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input addr_t a);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] %0t ns: load 0x%08h returned 0x%08h, expected 0x%08h",
                $time, a, got, exp));
        end
    endtask

    task automatic check_line(input line_t got, input line_t exp, input addr_t base);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] %0t ns: writeback 0x%08h sent 0x%032h, expected 0x%032h",
                $time, base, got, exp));
        end
    endtask

    function automatic word_t fill_word(input int i);
        return (word_t'(i) * 32'h9e3779b1) ^ 32'h0f1e2d3c;
    endfunction

    // flat view of memory as the CPU should see it
    function automatic word_t expected_load(input addr_t a);
        return shadow[a[9:2]];
    endfunction

    function automatic line_t shadow_line(input addr_t base);
        line_t l;
        for (int w = 0; w < LINE_WORDS; w++) begin
            l[32*w +: 32] = shadow[base[9:2] + w];
        end
        return l;
    endfunction

    task automatic store_shadow(input addr_t a, input word_t d, input strb_t s);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                shadow[a[9:2]][8*b +: 8] = d[8*b +: 8];
            end
        end
    endtask

    task automatic expect_latency(input bit is_hit);
        if (is_hit ? (last_latency != 2) : (last_latency <= 2)) begin
            stop_on_error($sformatf("[FAIL] %0t ns: latency %0d cycles, hit expected %0b",
                $time, last_latency, is_hit));
        end
    endtask

    // entered and left 5 ns after a rising edge
    task automatic access(input logic st, input addr_t a, input word_t d, input strb_t s);
        expect_t e;
        valid = 1'b1;
        op    = st;
        addr  = a;
        wdata = d;
        strb  = s;
        while (!cache_ready) begin
            @(posedge clk);
            #5;
        end
        @(posedge clk);
        #5;
        accept_cycle = cycles;
        e.st   = st;
        e.addr = a;
        e.data = expected_load(a);
        if (st) begin
            store_shadow(a, d, s);
        end
        exp_q.push_back(e);
        issued++;
        valid = 1'b0;
        while (resp_count < issued) begin
            @(negedge clk);
        end
        @(posedge clk);
        #5;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    always @(negedge clk) begin
        if (cycles > timeout_cycles) begin
            stop_on_error($sformatf("simulation timed out after %0d cycles", cycles));
        end
        if (i_dut.i_props.failures != 0) begin
            stop_on_error("a bus protocol assertion failed");
        end
    end

    always @(negedge clk) begin : compare
        expect_t e;
        if (!reset && data_valid) begin
            if (exp_q.size() == 0) begin
                stop_on_error("data_valid arrived with no request outstanding");
            end else begin
                e = exp_q.pop_front();
                // lookup cycle included
                last_latency = cycles - accept_cycle + 1;
                if (!e.st) begin
                    check_word(rdata, e.data, e.addr);
                end
                resp_count++;
            end
        end
    end

    initial begin : read_port
        addr_t rbase;
        r_rdy     = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        r_data    = '0;
        forever begin
            @(posedge clk);
            #5;
            if (!reset && r_req) begin
                rd_seen_cycle = cycles;
                repeat ($urandom_range(0, 3)) begin
                    @(posedge clk);
                    #5;
                end
                if (r_req !== 1'b1 || r_length !== 8'd3 || r_addr[3:0] !== 4'h0) begin
                    stop_on_error("read request dropped, not 4 beats long or not line-aligned");
                end
                r_rdy = 1'b1;
                rbase = r_addr;
                @(posedge clk);
                #5;
                r_rdy = 1'b0;
                for (int b = 0; b < LINE_WORDS; b++) begin
                    repeat ($urandom_range(0, 2)) begin
                        @(posedge clk);
                        #5;
                    end
                    ret_valid = 1'b1;
                    ret_last  = (b == LINE_WORDS - 1);
                    r_data    = mem[rbase[9:2] + b];
                    @(posedge clk);
                    #5;
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

    initial begin : write_port
        line_t wline;
        addr_t wbase;
        w_rdy        = 1'b0;
        w_data_ready = 1'b0;
        b_valid      = 1'b0;
        forever begin
            @(posedge clk);
            #5;
            if (!reset && w_req) begin
                repeat ($urandom_range(0, 3)) begin
                    @(posedge clk);
                    #5;
                end
                w_rdy = 1'b1;
                wbase = w_addr;
                @(posedge clk);
                #5;
                w_rdy = 1'b0;
                for (int b = 0; b < LINE_WORDS; b++) begin
                    repeat ($urandom_range(0, 2)) begin
                        @(posedge clk);
                        #5;
                    end
                    if (!w_data_req || (w_last !== (b == LINE_WORDS - 1))) begin
                        stop_on_error("write burst beat missing or w_last misplaced");
                    end
                    w_data_ready       = 1'b1;
                    wline[32*b +: 32] = w_data;
                    @(posedge clk);
                    #5;
                    w_data_ready = 1'b0;
                end
                repeat ($urandom_range(0, 3)) begin
                    @(posedge clk);
                    #5;
                end
                if (b_ready !== 1'b1) begin
                    stop_on_error("b_ready low while the write response is pending");
                end
                b_valid = 1'b1;
                @(posedge clk);
                #5;
                b_valid = 1'b0;
                for (int b = 0; b < LINE_WORDS; b++) begin
                    mem[wbase[9:2] + b] = wline[32*b +: 32];
                end
                check_line(wline, shadow_line(wbase), wbase);
                wb_count++;
                wb_end_cycle = cycles;
                last_wb_base = wbase;
            end
        end
    end

    initial begin
        int    wb_before;
        addr_t ra;
        void'($urandom(32'h7a480ec9));
        reset = 1'b1;
        valid = 1'b0;
        op    = 1'b0;
        addr  = '0;
        wdata = '0;
        strb  = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i]    = fill_word(i);
            shadow[i] = mem[i];
        end
        repeat (4) @(posedge clk);
        #5;
        reset = 1'b0;

        // cold misses, then a hit on the same word
        access(1'b0, 32'h0000_0004, '0, 4'hf);
        expect_latency(1'b0);
        access(1'b0, 32'h0000_0118, '0, 4'hf);
        expect_latency(1'b0);
        access(1'b0, 32'h0000_0118, '0, 4'hf);
        expect_latency(1'b1);

        // strobed store hits
        access(1'b1, 32'h0000_0110, 32'hdeadbeef, 4'b0011);
        expect_latency(1'b1);
        access(1'b1, 32'h0000_011c, 32'h1234_5678, 4'b1000);
        access(1'b1, 32'h0000_0118, 32'hcafe_f00d, 4'b0110);
        access(1'b0, 32'h0000_0110, '0, 4'hf);
        access(1'b0, 32'h0000_011c, '0, 4'hf);
        access(1'b0, 32'h0000_0118, '0, 4'hf);

        // store miss merges into the fill
        access(1'b1, 32'h0000_02a4, 32'h55aa_33cc, 4'b0101);
        access(1'b0, 32'h0000_02a4, '0, 4'hf);
        access(1'b0, 32'h0000_02a0, '0, 4'hf);

        // third tag in set 5 evicts the dirty LRU line
        access(1'b1, 32'h0000_0050, 32'h0bad_c0de, 4'b1111);
        access(1'b0, 32'h0000_0150, '0, 4'hf);
        wb_before = wb_count;
        access(1'b0, 32'h0000_0250, '0, 4'hf);
        if (wb_count != wb_before + 1 || last_wb_base != 32'h0000_0050) begin
            stop_on_error("dirty victim of set 5 was not written back");
        end
        if (wb_end_cycle > rd_seen_cycle) begin
            stop_on_error("refill read started before the writeback finished");
        end
        access(1'b0, 32'h0000_0050, '0, 4'hf);

        for (int n = 0; n < num_random; n++) begin
            ra = addr_t'($urandom_range(0, 255)) << 2;
            access(1'($urandom_range(0, 1)), ra, $urandom(), strb_t'($urandom_range(1, 15)));
        end

        if (fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== dcache.f ====
src/dcache_pkg.sv
src/tagv_array.sv
src/data_store.sv
src/refill_buffer.sv
src/writeback_buffer.sv
src/cache_fsm.sv
src/dcache.sv
bench/dcache_properties.sv
bench/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - src/dcache_pkg.sv
  - src/tagv_array.sv
  - src/data_store.sv
  - src/refill_buffer.sv
  - src/writeback_buffer.sv
  - src/cache_fsm.sv
  - src/dcache.sv
  - target: test
    files:
      - bench/dcache_properties.sv
      - bench/dcache_tb.sv
